//--- filelist.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/cpu_alu.sv
verilog/cpu_decode.sv
verilog/cpu_sequencer.sv
verilog/cpu_datapath.sv
verilog/cpu_top.sv
tests/cpu_chk.sv
tests/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - verilog

sources:
  - verilog/cpu_pkg.sv
  - verilog/cpu_alu.sv
  - verilog/cpu_decode.sv
  - verilog/cpu_sequencer.sv
  - verilog/cpu_datapath.sv
  - verilog/cpu_top.sv
  - target: test
    files:
      - tests/cpu_chk.sv
      - tests/cpu_tb.sv

//--- tests/cpu_tb.sv
// Programs use the supported subset with forward branches and an ideal one-cycle memory
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_tb;

    localparam int          NUM_INSTR  = 200;
    localparam logic [15:0] PROG_START = 16'h02FB;  // Prologue branch lands past 0300
    localparam int          WATCH_CYC  = 16 + NUM_INSTR * 4 * 2 + 500;

    logic                   clk;
    logic                   reset;
    logic [`CPU_ADDR_W-1:0] addr;
    logic [`CPU_DATA_W-1:0] rdata;
    logic [`CPU_DATA_W-1:0] wdata;
    logic                   we;
    logic                   rdy;

    logic [7:0]  mem [0:65535];  // Memory seen by the DUT
    logic [7:0]  mm  [0:65535];  // Copy used by the model
    logic [15:0] exp_addr [$];   // Expected writes in order
    logic [7:0]  exp_data [$];
    logic [15:0] jmp_addr;       // Final self-loop
    logic [7:0]  m_a;
    logic [7:0]  m_x;
    logic [7:0]  m_y;
    logic        m_c;
    logic        m_z;
    logic        m_v;
    logic        m_n;
    int          errors;
    int          wr_idx;
    int          acc_count;      // Accepted cycles since reset release
    int          jmp_seen;

    logic [7:0] imm_ops [0:8]  = '{8'hA9, 8'hA2, 8'hA0, 8'h09, 8'h29, 8'h49,
                                   8'h69, 8'hE9, 8'hC9};
    logic [7:0] zp_ops  [0:11] = '{8'hA5, 8'hA6, 8'hA4, 8'h05, 8'h25, 8'h45,
                                   8'h65, 8'hE5, 8'hC5, 8'h85, 8'h86, 8'h84};
    logic [7:0] abs_ops [0:11] = '{8'hAD, 8'hAE, 8'hAC, 8'h0D, 8'h2D, 8'h4D,
                                   8'h6D, 8'hED, 8'hCD, 8'h8D, 8'h8E, 8'h8C};
    logic [7:0] imp_ops [0:10] = '{8'hE8, 8'hC8, 8'hCA, 8'h88, 8'hAA, 8'h8A,
                                   8'hA8, 8'h98, 8'h18, 8'h38, 8'hEA};

    cpu_top UUT (
        .clk(clk), .reset(reset), .addr(addr), .rdata(rdata),
        .wdata(wdata), .we(we), .rdy(rdy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // Synchronous memory frozen while stalled
    always @(posedge clk) begin
        if (rdy) begin
            if (we)
                mem[addr] <= wdata;
            rdata <= #2 mem[addr];
        end
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic set_nz(input logic [7:0] val);
        m_z = (val == 8'h00);
        m_n = val[7];
    endtask

    // Add with carry for ADC and for SBC and CMP with the operand inverted
    task automatic add_flags(input logic [7:0] m, input logic cin, output logic [7:0] r);
        logic [8:0] s;
        int         sv;  // Signed sum
        s   = {1'b0, m_a} + {1'b0, m} + {8'h00, cin};
        sv  = int'($signed(m_a)) + int'($signed(m)) + int'(cin);
        r   = s[7:0];
        m_c = s[8];
        m_v = (sv > 127) || (sv < -128);  // Outside the signed byte range
    endtask

    // Loads and accumulator operations on one operand byte
    task automatic apply_op(input logic [7:0] op, input logic [7:0] m);
        logic [7:0] r;
        logic       v_keep;
        if (op[1:0] == 2'b01) begin
            case (op[7:5])
                3'b000: m_a = m_a | m;
                3'b001: m_a = m_a & m;
                3'b010: m_a = m_a ^ m;
                3'b011: begin
                    add_flags(m, m_c, r);
                    m_a = r;
                end
                3'b101: m_a = m;
                3'b110: begin  // CMP leaves A and V alone
                    v_keep = m_v;
                    add_flags(~m, 1'b1, r);
                    m_v = v_keep;
                    set_nz(r);
                end
                default: begin  // SBC
                    add_flags(~m, m_c, r);
                    m_a = r;
                end
            endcase
            if (op[7:5] != 3'b110)
                set_nz(m_a);
        end else if (op[1]) begin
            m_x = m;
            set_nz(m_x);
        end else begin
            m_y = m;
            set_nz(m_y);
        end
    endtask

    task automatic store_value(input logic [7:0] op, input logic [15:0] ea);
        logic [7:0] val;
        val = op[1] ? m_x : (op[0] ? m_a : m_y);  // 85/8D A, 86/8E X, 84/8C Y
        mm[ea] = val;
        exp_addr.push_back(ea);
        exp_data.push_back(val);
    endtask

    // Instruction-level run of the program until the final jump
    task automatic run_model();
        logic [15:0] pc;
        logic [15:0] ea;
        logic [7:0]  op;
        logic        flag;
        int          steps;
        pc = PROG_START;
        {m_a, m_x, m_y} = '0;
        {m_c, m_z, m_v, m_n} = '0;  // Reset clears the flags
        steps = 0;
        while (pc != jmp_addr && steps < 10000) begin
            op = mm[pc];
            steps++;
            if (op inside {imm_ops}) begin
                apply_op(op, mm[pc + 16'd1]);
                pc += 16'd2;
            end else if (op inside {zp_ops} || op inside {abs_ops}) begin
                ea = (op[3]) ? {mm[pc + 16'd2], mm[pc + 16'd1]} : {8'h00, mm[pc + 16'd1]};
                if (op[7:5] == 3'b100)
                    store_value(op, ea);
                else
                    apply_op(op, mm[ea]);
                pc += op[3] ? 16'd3 : 16'd2;
            end else if (op[4:0] == 5'b10000) begin  // Conditional branch
                case (op[7:6])
                    2'b00:   flag = m_n;
                    2'b01:   flag = m_v;
                    2'b10:   flag = m_c;
                    default: flag = m_z;
                endcase
                pc += 16'd2;
                if (flag == op[5])
                    pc += {{8{mm[pc - 16'd1][7]}}, mm[pc - 16'd1]};
            end else begin
                case (op)
                    8'hE8: begin
                        m_x = m_x + 8'd1;
                        set_nz(m_x);
                    end
                    8'hC8: begin
                        m_y = m_y + 8'd1;
                        set_nz(m_y);
                    end
                    8'hCA: begin
                        m_x = m_x - 8'd1;
                        set_nz(m_x);
                    end
                    8'h88: begin
                        m_y = m_y - 8'd1;
                        set_nz(m_y);
                    end
                    8'hAA: begin
                        m_x = m_a;
                        set_nz(m_x);
                    end
                    8'h8A: begin
                        m_a = m_x;
                        set_nz(m_a);
                    end
                    8'hA8: begin
                        m_y = m_a;
                        set_nz(m_y);
                    end
                    8'h98: begin
                        m_a = m_y;
                        set_nz(m_a);
                    end
                    8'h18: m_c = 1'b0;
                    8'h38: m_c = 1'b1;
                    default: ;  // NOP
                endcase
                pc += 16'd1;
            end
        end
    endtask

    // Random program with forward branches over one or two instructions
    task automatic build_program();
        logic [15:0] pc;
        logic [15:0] br_pos;
        logic [7:0]  op;
        int          br_left;
        int          kind;
        pc = PROG_START;
        mem[pc] = 8'h38;          // SEC so the next branch is taken
        mem[pc + 16'd1] = 8'hB0;  // BCS over two instructions into page 03
        br_pos  = pc + 16'd1;
        br_left = 2;
        pc += 16'd3;
        for (int i = 0; i < NUM_INSTR; i++) begin
            kind = $urandom % 10;
            if (kind == 8 && br_left > 0)
                kind = 6;  // One pending branch at a time
            case (kind)
                0, 1: begin
                    mem[pc] = imm_ops[$urandom % 9];
                    mem[pc + 16'd1] = 8'($urandom);
                    pc += 16'd2;
                end
                2, 3, 9: begin
                    op = (kind == 9) ? zp_ops[9 + $urandom % 3] : zp_ops[$urandom % 12];
                    mem[pc] = op;
                    mem[pc + 16'd1] = 8'h10 + 8'($urandom % 16);  // Zero-page data
                    pc += 16'd2;
                end
                4, 5: begin
                    mem[pc] = abs_ops[$urandom % 12];
                    mem[pc + 16'd1] = 8'($urandom);
                    mem[pc + 16'd2] = 8'h30;  // Absolute data page
                    pc += 16'd3;
                end
                8: begin
                    mem[pc] = {3'($urandom), 5'b10000};
                    br_pos  = pc;
                    br_left = 1 + $urandom % 2;
                    pc += 16'd2;
                    continue;
                end
                default: begin
                    mem[pc] = imp_ops[$urandom % 11];
                    pc += 16'd1;
                end
            endcase
            if (br_left > 0) begin
                br_left--;
                if (br_left == 0)
                    mem[br_pos + 16'd1] = 8'(pc - br_pos - 16'd2);
            end
        end
        if (br_left > 0)
            mem[br_pos + 16'd1] = 8'(pc - br_pos - 16'd2);  // Lands on the final jump
        jmp_addr = pc;
        mem[pc] = 8'h4C;
        mem[pc + 16'd1] = pc[7:0];
        mem[pc + 16'd2] = pc[15:8];
        mem[16'hFFFC] = PROG_START[7:0];
        mem[16'hFFFD] = PROG_START[15:8];
    endtask

    // Bus monitor at the falling edge, where all DUT outputs are settled
    always @(negedge clk) begin
        if (reset) begin
            if (we) begin
                errors++;
                $display("Write enable was high during reset");
            end
        end else if (rdy) begin
            acc_count++;
            if (acc_count == 1)
                check_value("addr", addr, `CPU_RESET_VECTOR);
            if (acc_count == 2)
                check_value("addr", addr, `CPU_RESET_VECTOR + 16'd1);
            if (acc_count == 3)
                check_value("addr", addr, PROG_START);
            if (addr == jmp_addr)
                jmp_seen++;
            if (we) begin
                if (wr_idx < exp_addr.size()) begin
                    check_value("addr", addr, exp_addr[wr_idx]);
                    check_value("wdata", wdata, exp_data[wr_idx]);
                end else begin
                    errors++;
                    $display("Write to %h seen after the expected writes ran out", addr);
                end
                wr_idx++;
            end
        end
    end

    initial begin
        #(WATCH_CYC * 40);
        $display("Watchdog expired, the core hung before looping on the final jump");
        $display("test failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        rdy = 1'b1;
        rdata = '0;
        errors = 0;
        wr_idx = 0;
        acc_count = 0;
        jmp_seen = 0;
        jmp_addr = 16'hFFFF;
        void'($urandom(32'h1ccbb362));
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'(i[7:0] ^ i[15:8] ^ 8'h5A);  // Whole-address fill
        build_program();
        for (int i = 0; i < 65536; i++)
            mm[i] = mem[i];
        run_model();
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;
        fork
            forever begin  // Random stall in about a quarter of cycles
                @(posedge clk);
                #2 rdy = ($urandom % 4) != 0;
            end
        join_none
        wait (jmp_seen >= 3);
        repeat (20) @(posedge clk);  // No writes may follow the final loop
        check_value("write_count", 16'(wr_idx), 16'(exp_addr.size()));
        $display("errors %0d, writes checked %0d of %0d", errors, wr_idx, exp_addr.size());
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- tests/cpu_chk.sv
// Bus checks assume rdy low freezes the core and every store lasts one accepted cycle
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_chk (
    input logic                   clk,
    input logic                   reset,
    input logic                   rdy,
    input logic [`CPU_ADDR_W-1:0] addr,
    input logic [`CPU_DATA_W-1:0] wdata,
    input logic                   we
);

    // Outputs frozen through a stall
    assert property (@(posedge clk) disable iff (reset) !rdy |=> $stable(addr))
        else $error("addr changed while rdy was low");
    assert property (@(posedge clk) disable iff (reset) !rdy |=> $stable(we))
        else $error("we changed while rdy was low");
    assert property (@(posedge clk) disable iff (reset) !rdy |=> $stable(wdata))
        else $error("wdata changed while rdy was low");

    assert property (@(posedge clk) reset |-> !we)
        else $error("we high during reset");

    // Single accepted write per store
    assert property (@(posedge clk) disable iff (reset) (we && rdy) |=> !we)
        else $error("we high for two accepted cycles");

endmodule

bind cpu_top cpu_chk u_chk (.*);

//--- verilog/cpu_top.sv
// Synchronous memory with one-cycle read latency is assumed on the separate read and write buses
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    output logic [`CPU_ADDR_W-1:0] addr,
    input  logic [`CPU_DATA_W-1:0] rdata,
    output logic [`CPU_DATA_W-1:0] wdata,
    output logic                   we,
    input  logic                   rdy
);

    cpu_state_t             state;
    reg_sel_t               src_reg;
    reg_sel_t               dst_reg;
    logic                   load_reg;
    logic                   load_only;
    logic                   store;
    logic                   compare;
    logic                   adc_sbc;
    logic                   inc;
    logic                   set_c;
    logic                   clr_c;
    alu_op_t                alu_op_sel;
    logic [2:0]             cond_code;
    logic [`CPU_DATA_W-1:0] ai;
    logic [`CPU_DATA_W-1:0] bi;
    logic                   ci;
    alu_op_t                op;
    logic [`CPU_DATA_W-1:0] result;
    logic                   co;
    logic                   v;
    logic                   z;
    logic                   n;
    logic                   cond_true;
    logic [`CPU_DATA_W-1:0] pcl;

    cpu_alu u_alu (
        .clk(clk), .rdy(rdy), .op(op), .ai(ai), .bi(bi), .ci(ci),
        .result(result), .co(co), .v(v), .z(z), .n(n)
    );

    cpu_decode u_decode (
        .clk(clk), .reset(reset), .rdy(rdy), .state(state), .rdata(rdata),
        .src_reg(src_reg), .dst_reg(dst_reg), .load_reg(load_reg),
        .load_only(load_only), .store(store), .compare(compare),
        .adc_sbc(adc_sbc), .inc(inc), .set_c(set_c), .clr_c(clr_c),
        .alu_op_sel(alu_op_sel), .cond_code(cond_code)
    );

    cpu_sequencer u_sequencer (
        .clk(clk), .reset(reset), .rdy(rdy), .rdata(rdata), .result(result),
        .co(co), .store(store), .cond_true(cond_true), .state(state),
        .pcl(pcl), .addr(addr), .we(we)
    );

    cpu_datapath u_datapath (
        .clk(clk), .reset(reset), .rdy(rdy), .state(state), .rdata(rdata),
        .pcl(pcl), .result(result), .co(co), .v(v), .z(z), .n(n),
        .src_reg(src_reg), .dst_reg(dst_reg), .load_reg(load_reg),
        .load_only(load_only), .compare(compare), .adc_sbc(adc_sbc),
        .inc(inc), .set_c(set_c), .clr_c(clr_c), .alu_op_sel(alu_op_sel),
        .cond_code(cond_code), .ai(ai), .bi(bi), .ci(ci), .op(op),
        .cond_true(cond_true), .wdata(wdata)
    );

endmodule

//--- verilog/cpu_datapath.sv
// Register and flag write-back lands in DECODE and assumes the ALU result is from FETCH or REG
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_datapath
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rdy,
    input  cpu_state_t             state,
    input  logic [`CPU_DATA_W-1:0] rdata,
    input  logic [`CPU_DATA_W-1:0] pcl,
    input  logic [`CPU_DATA_W-1:0] result,
    input  logic                   co,
    input  logic                   v,
    input  logic                   z,
    input  logic                   n,
    input  reg_sel_t               src_reg,
    input  reg_sel_t               dst_reg,
    input  logic                   load_reg,
    input  logic                   load_only,
    input  logic                   compare,
    input  logic                   adc_sbc,
    input  logic                   inc,
    input  logic                   set_c,
    input  logic                   clr_c,
    input  alu_op_t                alu_op_sel,
    input  logic [2:0]             cond_code,
    output logic [`CPU_DATA_W-1:0] ai,
    output logic [`CPU_DATA_W-1:0] bi,
    output logic                   ci,
    output alu_op_t                op,
    output logic                   cond_true,
    output logic [`CPU_DATA_W-1:0] wdata
);

    logic [`CPU_DATA_W-1:0] a_reg;
    logic [`CPU_DATA_W-1:0] x_reg;
    logic [`CPU_DATA_W-1:0] y_reg;
    logic [`CPU_DATA_W-1:0] src_val;  // Selected source register
    logic                   c_flag;
    logic                   z_flag;
    logic                   v_flag;
    logic                   n_flag;
    logic                   flag_sel;
    logic                   wb;       // Write-back cycle

    assign wb = rdy && state == DECODE;

    always_comb begin
        case (src_reg)
            SEL_X:   src_val = x_reg;
            SEL_Y:   src_val = y_reg;
            default: src_val = a_reg;
        endcase
    end

    assign wdata = src_val;  // Store data

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            a_reg <= '0;
            x_reg <= '0;
            y_reg <= '0;
        end else if (wb && load_reg) begin
            case (dst_reg)
                SEL_X:   x_reg <= result;
                SEL_Y:   y_reg <= result;
                default: a_reg <= result;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            c_flag <= 1'b0;
            z_flag <= 1'b0;
            v_flag <= 1'b0;
            n_flag <= 1'b0;
        end else if (wb) begin
            if (adc_sbc | compare)
                c_flag <= co;
            else if (set_c)
                c_flag <= 1'b1;
            else if (clr_c)
                c_flag <= 1'b0;
            if (load_reg | compare) begin  // CMP sets Z/N without a write
                z_flag <= z;
                n_flag <= n;
            end
            if (adc_sbc)
                v_flag <= v;
        end
    end

    always_comb begin
        ai = '0;
        bi = '0;
        ci = 1'b0;
        op = OP_PASS;
        case (state)
            FETCH: begin
                ai = load_only ? '0 : src_val;
                bi = rdata;
                ci = compare | (~load_only & c_flag);  // CMP forces no borrow
                op = alu_op_sel;
            end
            REG: begin
                ai = src_val;
                ci = inc;
                op = alu_op_sel;
            end
            RST1, JMP0, ABS0: ai = rdata;  // Hold low address byte
            BRA0: begin
                ai = rdata;
                bi = pcl;
                op = OP_ADD;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (cond_code[2:1])
            2'b00:   flag_sel = n_flag;  // BPL, BMI
            2'b01:   flag_sel = v_flag;  // BVC, BVS
            2'b10:   flag_sel = c_flag;  // BCC, BCS
            default: flag_sel = z_flag;  // BNE, BEQ
        endcase
    end

    assign cond_true = (flag_sel == cond_code[0]);

endmodule

//--- verilog/cpu_sequencer.sv
// Memory must return read data one cycle after addr and hold rdata while rdy is low
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_sequencer
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rdy,
    input  logic [`CPU_DATA_W-1:0] rdata,
    input  logic [`CPU_DATA_W-1:0] result,
    input  logic                   co,
    input  logic                   store,
    input  logic                   cond_true,
    output cpu_state_t             state,
    output logic [`CPU_DATA_W-1:0] pcl,
    output logic [`CPU_ADDR_W-1:0] addr,
    output logic                   we
);

    cpu_state_t             state_next;
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] pc_temp;  // Base of next PC
    logic                   pc_inc;   // Add one to pc_temp
    logic [`CPU_ADDR_W-1:0] ab_hold;  // Previous cycle address
    logic [`CPU_DATA_W-1:0] hi_fix;   // Corrected page after a crossing
    logic                   backwards;

    assign pcl    = pc[`CPU_DATA_W-1:0];
    assign hi_fix = ab_hold[`CPU_ADDR_W-1:`CPU_DATA_W] + (backwards ? 8'hFF : 8'h01);

    always_comb begin
        case (state)
            RST0:   state_next = RST1;
            RST1:   state_next = JMP1;  // Vector load shares the jump path
            DECODE: begin
                casez (rdata)
                    8'h4C:        state_next = JMP0;
                    8'b???1_0000: state_next = BRA0;
                    8'h89:        state_next = REG;    // Runs as NOP
                    8'b???0_1001,
                    8'b1010_00?0: state_next = FETCH;  // Immediate
                    8'b???0_0101,
                    8'b10?0_01?0: state_next = ZP0;
                    8'b???0_1101,
                    8'b10?0_11?0: state_next = ABS0;
                    default:      state_next = REG;    // Implied and unknown
                endcase
            end
            ZP0:    state_next = FETCH;
            ABS0:   state_next = ABS1;
            ABS1:   state_next = FETCH;
            BRA0:   state_next = cond_true ? BRA1 : DECODE;
            BRA1:   state_next = (co ^ backwards) ? BRA2 : DECODE;  // Page crossed
            JMP0:   state_next = JMP1;
            default: state_next = DECODE;  // FETCH, REG, BRA2, JMP1
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state <= RST0;
        else if (rdy)
            state <= state_next;
    end

    always_comb begin
        pc_temp = pc;
        pc_inc  = 1'b0;
        case (state)
            DECODE, FETCH, ABS0, BRA0: pc_inc = 1'b1;
            JMP1: begin
                pc_temp = {rdata, result};
                pc_inc  = 1'b1;
            end
            BRA1: begin
                pc_temp = {ab_hold[`CPU_ADDR_W-1:`CPU_DATA_W], result};
                pc_inc  = ~(co ^ backwards);  // Held back when BRA2 follows
            end
            BRA2: begin
                pc_temp = {hi_fix, pcl};
                pc_inc  = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            pc      <= pc_temp + {{(`CPU_ADDR_W-1){1'b0}}, pc_inc};
            ab_hold <= addr;
            if (state == BRA0)
                backwards <= rdata[`CPU_DATA_W-1];  // Offset sign
        end
    end

    always_comb begin
        case (state)
            RST0:       addr = `CPU_RESET_VECTOR;
            RST1:       addr = `CPU_RESET_VECTOR + 16'd1;
            ZP0:        addr = {`CPU_ZERO_PAGE, rdata};
            JMP1, ABS1: addr = {rdata, result};  // Low byte held in ALU
            BRA1:       addr = {ab_hold[`CPU_ADDR_W-1:`CPU_DATA_W], result};
            BRA2:       addr = {hi_fix, ab_hold[`CPU_DATA_W-1:0]};
            REG:        addr = ab_hold;  // Re-read the next opcode
            default:    addr = pc;
        endcase
    end

    assign we = store & (state == ZP0 || state == ABS1);

endmodule

//--- verilog/cpu_decode.sv
// Controls load only in DECODE with rdy high and stay valid until the next DECODE
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_decode
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rdy,
    input  cpu_state_t             state,
    input  logic [`CPU_DATA_W-1:0] rdata,
    output reg_sel_t               src_reg,
    output reg_sel_t               dst_reg,
    output logic                   load_reg,
    output logic                   load_only,
    output logic                   store,
    output logic                   compare,
    output logic                   adc_sbc,
    output logic                   inc,
    output logic                   set_c,
    output logic                   clr_c,
    output alu_op_t                alu_op_sel,
    output logic [2:0]             cond_code
);

    logic     known;  // Opcode is in the supported set
    logic     load_reg_d;
    reg_sel_t src_d;
    reg_sel_t dst_d;
    alu_op_t  op_d;

    always_comb begin
        casez (rdata)
            8'h89:        known = 1'b0;  // Empty immediate slot
            8'b???0_0101,
            8'b???0_1001,
            8'b???0_1101: known = 1'b1;  // A column zp, imm, abs
            8'b10?0_01?0,
            8'b10?0_11?0,
            8'b1010_00?0: known = 1'b1;  // X/Y loads and stores
            8'b1??0_1000,
            8'b1?00_1010,
            8'h98, 8'hAA: known = 1'b1;  // INC/DEC and transfers
            8'b00?1_1000: known = 1'b1;  // CLC, SEC
            8'b???1_0000: known = 1'b1;  // Conditional branches
            8'h4C:        known = 1'b1;  // JMP abs
            default:      known = 1'b0;
        endcase

        casez (rdata)
            8'b0??0_??01,               // ORA, AND, EOR, ADC
            8'b1?10_??01,               // LDA, SBC
            8'b1010_???0,               // LDX, LDY, TAX, TAY
            8'b100?_10?0,               // DEY, TXA, TYA
            8'b11?0_10?0: load_reg_d = 1'b1;  // INY, DEX, INX
            default:      load_reg_d = 1'b0;
        endcase

        casez (rdata)
            8'hE8, 8'hCA,
            8'b1010_??10: dst_d = SEL_X;  // LDX, TAX
            8'b1?00_1000,
            8'b1010_??00: dst_d = SEL_Y;  // LDY, TAY
            default:      dst_d = SEL_A;
        endcase

        casez (rdata)
            8'b1000_?110,
            8'h8A, 8'hE8, 8'hCA: src_d = SEL_X;  // STX, TXA, INX, DEX
            8'b1000_?100,
            8'h98, 8'b1?00_1000: src_d = SEL_Y;  // STY, TYA, INY, DEY
            default:             src_d = SEL_A;
        endcase

        casez (rdata)
            8'b000?_??01: op_d = OP_OR;
            8'b001?_??01: op_d = OP_AND;
            8'b010?_??01: op_d = OP_EOR;
            8'b11??_??01,
            8'h88, 8'hCA: op_d = OP_SUB;  // CMP, SBC, DEY, DEX
            default:      op_d = OP_ADD;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            src_reg    <= SEL_A;
            dst_reg    <= SEL_A;
            load_reg   <= 1'b0;
            load_only  <= 1'b0;
            store      <= 1'b0;
            compare    <= 1'b0;
            adc_sbc    <= 1'b0;
            inc        <= 1'b0;
            set_c      <= 1'b0;
            clr_c      <= 1'b0;
            alu_op_sel <= OP_ADD;
            cond_code  <= 3'd0;
        end else if (rdy && state == DECODE) begin  // Unknown opcodes clear everything
            src_reg    <= known ? src_d : SEL_A;
            dst_reg    <= known ? dst_d : SEL_A;
            load_reg   <= known & load_reg_d;
            load_only  <= known & (rdata[7:5] == 3'b101);  // LDA, LDX, LDY
            store      <= known & (rdata[7:4] == 4'h8) & rdata[2];
            compare    <= known & (rdata[7:5] == 3'b110) & (rdata[1:0] == 2'b01);
            adc_sbc    <= known & (rdata[6:5] == 2'b11) & (rdata[1:0] == 2'b01);
            inc        <= known & (rdata == 8'hC8 || rdata == 8'hE8);
            set_c      <= (rdata == 8'h38);
            clr_c      <= (rdata == 8'h18);
            alu_op_sel <= known ? op_d : OP_ADD;
            cond_code  <= known ? rdata[7:5] : 3'd0;  // Flag select and value
        end
    end

endmodule

//--- verilog/cpu_alu.sv
// Result, carry and overflow are registered and update only on cycles with rdy high
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_alu
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rdy,
    input  alu_op_t                op,
    input  logic [`CPU_DATA_W-1:0] ai,
    input  logic [`CPU_DATA_W-1:0] bi,
    input  logic                   ci,
    output logic [`CPU_DATA_W-1:0] result,
    output logic                   co,
    output logic                   v,
    output logic                   z,
    output logic                   n
);

    logic [`CPU_DATA_W-1:0] b_eff;  // Inverted for subtract
    logic [`CPU_DATA_W:0]   sum;    // Carry in top bit
    logic [`CPU_DATA_W-1:0] out_d;
    logic                   co_d;
    logic                   v_d;

    assign b_eff = (op == OP_SUB) ? ~bi : bi;
    assign sum   = {1'b0, ai} + {1'b0, b_eff} + {{`CPU_DATA_W{1'b0}}, ci};

    always_comb begin
        co_d = sum[`CPU_DATA_W];
        // Same operand signs but result sign flipped
        v_d  = (ai[`CPU_DATA_W-1] == b_eff[`CPU_DATA_W-1]) &&
               (sum[`CPU_DATA_W-1] != ai[`CPU_DATA_W-1]);
        case (op)
            OP_OR:   out_d = ai | bi;
            OP_AND:  out_d = ai & bi;
            OP_EOR:  out_d = ai ^ bi;
            OP_PASS: out_d = ai;
            default: out_d = sum[`CPU_DATA_W-1:0];  // ADD and SUB
        endcase
    end

    always_ff @(posedge clk) begin
        if (rdy) begin  // Frozen while stalled
            result <= out_d;
            co     <= co_d;
            v      <= v_d;
        end
    end

    assign z = (result == '0);
    assign n = result[`CPU_DATA_W-1];

endmodule

//--- verilog/cpu_pkg.sv
// Enum encodings are internal to the core and may change without notice to bus users
package cpu_pkg;

    // Microcode states
    typedef enum logic [3:0] {
        RST0,   // Vector low byte address
        RST1,   // Vector high byte address
        DECODE, // Opcode on rdata, previous write-back
        FETCH,  // Operand on rdata, ALU runs
        REG,    // Register-only instruction
        ZP0,    // Zero-page access
        ABS0,   // Absolute low byte
        ABS1,   // Absolute high byte and access
        BRA0,   // Offset read, PCL plus offset
        BRA1,   // Taken branch target
        BRA2,   // Page-crossing fix
        JMP0,   // Jump low byte
        JMP1    // Jump high byte
    } cpu_state_t;

    // ALU operations
    typedef enum logic [2:0] {
        OP_OR,
        OP_AND,
        OP_EOR,
        OP_ADD,  // ai + bi + ci
        OP_SUB,  // ai + ~bi + ci
        OP_PASS  // ai through
    } alu_op_t;

    // Register file index
    typedef enum logic [1:0] {
        SEL_A,
        SEL_X,
        SEL_Y
    } reg_sel_t;

endpackage

//--- verilog/cpu_config.svh
// Core widths are fixed at 8-bit data and 16-bit address and cannot be changed here
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_DATA_W       8        // Data bus width
`define CPU_ADDR_W       16       // Address bus width
`define CPU_ZERO_PAGE    8'h00    // High byte of zero-page accesses
`define CPU_RESET_VECTOR 16'hFFFC // Low vector byte, high byte follows at +1

`endif
